//--- mem_issue_pkg.sv
`default_nettype none

package mem_issue_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // widths shared by the station, the memory unit and the top level
    ////////////////////////////////////////////////////////////////////////////

    parameter int xlen      = 32;   // data and address width
    parameter int prf_len   = 6;    // physical register tag
    parameter int rob_len   = 5;    // reorder buffer index
    parameter int mem_words = 64;   // data memory depth in words

    ////////////////////////////////////////////////////////////////////////////
    // memory functions
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        mem_lw  = 3'd0, // load word
        mem_lb  = 3'd1, // load byte, sign extended
        mem_lbu = 3'd2, // load byte, zero extended
        mem_sw  = 3'd3, // store word
        mem_sb  = 3'd4  // store byte
    } mem_func_t;

    // true for both store flavours
    function automatic logic is_store(input mem_func_t func);
        return (func == mem_sw) || (func == mem_sb);
    endfunction

endpackage

`default_nettype wire

//--- psel_gen.sv
`timescale 1ns/10ps
`default_nettype none

// lowest index first, one grant per cycle
module psel_gen #(
    parameter int width = 8
) (
    input  wire logic [width-1:0] req,
    output logic      [width-1:0] gnt,
    output logic                  empty
);

    logic [width-1:0] req_neg;

    // two's complement keeps only the lowest set bit when and-ed back
    assign req_neg = ~req + width'(1);
    assign gnt     = req & req_neg;

    assign empty = ~|req;   // nothing ready this cycle

endmodule

`default_nettype wire

//--- rs_mem.sv
`timescale 1ns/10ps
`default_nettype none

module rs_mem import mem_issue_pkg::*; #(
    parameter int rs_size = 8
) (
    input  wire logic               clock,
    input  wire logic               rst_n,
    // dispatch
    input  wire logic               enable,
    input  wire mem_func_t          mem_func,
    input  wire logic [prf_len-1:0] opa_preg_idx,
    input  wire logic [prf_len-1:0] opb_preg_idx,
    input  wire logic               opa_ready,
    input  wire logic               opb_ready,
    input  wire logic [xlen-1:0]    opa_value,
    input  wire logic [xlen-1:0]    opb_value,
    input  wire logic [xlen-1:0]    offset,
    input  wire logic [prf_len-1:0] dest_preg_idx,
    input  wire logic [rob_len-1:0] rob_idx,
    // common data bus
    input  wire logic               cdb_valid,
    input  wire logic [prf_len-1:0] cdb_tag,
    input  wire logic [xlen-1:0]    cdb_value,
    input  wire logic               commit_mis_pred,
    output logic                    full,
    // issue to the memory unit
    output logic                    issue_valid,
    output mem_func_t               issue_func,
    output logic [xlen-1:0]         issue_base,
    output logic [xlen-1:0]         issue_data,
    output logic [xlen-1:0]         issue_offset,
    output logic [prf_len-1:0]      issue_dest_preg_idx,
    output logic [rob_len-1:0]      issue_rob_idx
);

    localparam int idx_w = (rs_size > 1) ? $clog2(rs_size) : 1;
    localparam int cnt_w = $clog2(rs_size + 1);

    // entry storage
    mem_func_t          ent_func [rs_size];
    logic [xlen-1:0]    ent_opa  [rs_size];    // value once ready
    logic [xlen-1:0]    ent_opb  [rs_size];
    logic [prf_len-1:0] ent_tag_a[rs_size];    // tag while waiting
    logic [prf_len-1:0] ent_tag_b[rs_size];
    logic [xlen-1:0]    ent_offset[rs_size];
    logic [prf_len-1:0] ent_dest [rs_size];
    logic [rob_len-1:0] ent_rob  [rs_size];
    logic [rs_size-1:0] ent_rdy_a;
    logic [rs_size-1:0] ent_rdy_b;
    logic [rs_size-1:0] ent_free;

    logic [cnt_w-1:0]   count;
    logic [idx_w-1:0]   free_idx;
    logic [idx_w-1:0]   sel_idx;
    logic [rs_size-1:0] req;
    logic [rs_size-1:0] gnt;
    logic               none_ready;
    logic               wake_a, wake_b;     // cdb hit on the incoming operands

    assign full = (count == cnt_w'(rs_size));

    ////////////////////////////////////////////////////////////////////////////
    // slot search, ready detection and selection
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        free_idx = '0;
        for (int i = rs_size - 1; i >= 0; i--) begin
            if (ent_free[i]) free_idx = idx_w'(i);     // lowest free wins
        end
    end

    assign req = ~ent_free & ent_rdy_a & ent_rdy_b;

    psel_gen #(.width(rs_size)) i_psel_gen (
        .req  (req),
        .gnt  (gnt),
        .empty(none_ready)
    );

    always_comb begin
        sel_idx = '0;
        for (int j = 0; j < rs_size; j++) begin
            if (gnt[j]) sel_idx = idx_w'(j);
        end
    end

    // a broadcast in the dispatch cycle must not slip past the new entry
    assign wake_a = cdb_valid && (cdb_tag == opa_preg_idx);
    assign wake_b = cdb_valid && (cdb_tag == opb_preg_idx);

    ////////////////////////////////////////////////////////////////////////////
    // control state
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (!rst_n || commit_mis_pred) begin
            ent_free    <= '1;
            count       <= '0;
            issue_valid <= 1'b0;
        end else begin
            count       <= count + cnt_w'(enable) - cnt_w'(!none_ready);
            issue_valid <= !none_ready;
            if (!none_ready) ent_free[sel_idx] <= 1'b1;    // leaves as it issues
            if (enable)      ent_free[free_idx] <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // entry payload, wakeup and issue register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        for (int t = 0; t < rs_size; t++) begin
            if (cdb_valid && !ent_free[t]) begin
                if (!ent_rdy_a[t] && ent_tag_a[t] == cdb_tag) begin
                    ent_rdy_a[t] <= 1'b1;
                    ent_opa[t]   <= cdb_value;
                end
                if (!ent_rdy_b[t] && ent_tag_b[t] == cdb_tag) begin
                    ent_rdy_b[t] <= 1'b1;
                    ent_opb[t]   <= cdb_value;
                end
            end
        end

        if (enable) begin
            ent_func[free_idx]   <= mem_func;
            ent_rdy_a[free_idx]  <= opa_ready || wake_a;
            ent_rdy_b[free_idx]  <= opb_ready || wake_b;
            ent_opa[free_idx]    <= opa_ready ? opa_value : cdb_value;
            ent_opb[free_idx]    <= opb_ready ? opb_value : cdb_value;
            ent_tag_a[free_idx]  <= opa_preg_idx;
            ent_tag_b[free_idx]  <= opb_preg_idx;
            ent_offset[free_idx] <= offset;
            ent_dest[free_idx]   <= dest_preg_idx;
            ent_rob[free_idx]    <= rob_idx;
        end

        if (!none_ready) begin
            issue_func          <= ent_func[sel_idx];
            issue_base          <= ent_opa[sel_idx];
            issue_data          <= ent_opb[sel_idx];
            issue_offset        <= ent_offset[sel_idx];
            issue_dest_preg_idx <= ent_dest[sel_idx];
            issue_rob_idx       <= ent_rob[sel_idx];
        end
    end

endmodule

`default_nettype wire

//--- mem_unit.sv
`timescale 1ns/10ps
`default_nettype none

module mem_unit import mem_issue_pkg::*; (
    input  wire logic               clock,
    input  wire logic               rst_n,
    input  wire logic               commit_mis_pred,
    // issue from the station
    input  wire logic               issue_valid,
    input  wire mem_func_t          issue_func,
    input  wire logic [xlen-1:0]    issue_base,
    input  wire logic [xlen-1:0]    issue_data,
    input  wire logic [xlen-1:0]    issue_offset,
    input  wire logic [prf_len-1:0] issue_dest_preg_idx,
    input  wire logic [rob_len-1:0] issue_rob_idx,
    // completion
    output logic                    result_valid,
    output logic                    result_is_store,
    output logic [rob_len-1:0]      result_rob_idx,
    output logic [prf_len-1:0]      result_dest_preg_idx,
    output logic [xlen-1:0]         result_value
);

    localparam int word_w = $clog2(mem_words);

    logic [xlen-1:0]   mem [mem_words];
    logic [xlen-1:0]   addr;
    logic [word_w-1:0] word_idx;
    logic [1:0]        lane;
    logic [xlen-1:0]   rd_word;
    logic [7:0]        rd_byte;
    logic [xlen-1:0]   st_word;     // value written, also reported for stores
    logic [xlen-1:0]   ld_value;
    logic              do_op;

    ////////////////////////////////////////////////////////////////////////////
    // address generation and lane handling
    ////////////////////////////////////////////////////////////////////////////

    assign addr     = issue_base + issue_offset;
    assign word_idx = addr[word_w+1:2];     // wraps modulo the depth
    assign lane     = addr[1:0];
    assign rd_word  = mem[word_idx];
    assign rd_byte  = rd_word[8*lane +: 8];

    assign st_word = (issue_func == mem_sb) ? {(xlen / 8){issue_data[7:0]}} : issue_data;

    always_comb begin
        case (issue_func)
            mem_lb:  ld_value = {{(xlen-8){rd_byte[7]}}, rd_byte};
            mem_lbu: ld_value = {{(xlen-8){1'b0}}, rd_byte};
            default: ld_value = rd_word;
        endcase
    end

    assign do_op = issue_valid && !commit_mis_pred;     // a flush cancels the op

    ////////////////////////////////////////////////////////////////////////////
    // data memory and completion registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int w = 0; w < mem_words; w++) mem[w] <= '0;
        end else if (do_op && issue_func == mem_sw) begin
            mem[word_idx] <= st_word;
        end else if (do_op && issue_func == mem_sb) begin
            mem[word_idx][8*lane +: 8] <= st_word[7:0];  // single byte lane
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) result_valid <= 1'b0;
        else        result_valid <= do_op;
    end

    always_ff @(posedge clock) begin
        if (do_op) begin
            result_is_store      <= is_store(issue_func);
            result_rob_idx       <= issue_rob_idx;
            result_dest_preg_idx <= issue_dest_preg_idx;
            result_value         <= is_store(issue_func) ? st_word : ld_value;
        end
    end

endmodule

`default_nettype wire

//--- mem_issue_top.sv
`timescale 1ns/10ps
`default_nettype none

module mem_issue_top import mem_issue_pkg::*; #(
    parameter int rs_size = 8
) (
    input  wire logic               clock,
    input  wire logic               rst_n,
    // dispatch
    input  wire logic               enable,
    input  wire mem_func_t          mem_func,
    input  wire logic [prf_len-1:0] opa_preg_idx,
    input  wire logic [prf_len-1:0] opb_preg_idx,
    input  wire logic               opa_ready,
    input  wire logic               opb_ready,
    input  wire logic [xlen-1:0]    opa_value,
    input  wire logic [xlen-1:0]    opb_value,
    input  wire logic [xlen-1:0]    offset,
    input  wire logic [prf_len-1:0] dest_preg_idx,
    input  wire logic [rob_len-1:0] rob_idx,
    // common data bus and flush
    input  wire logic               cdb_valid,
    input  wire logic [prf_len-1:0] cdb_tag,
    input  wire logic [xlen-1:0]    cdb_value,
    input  wire logic               commit_mis_pred,
    output logic                    full,
    // completion
    output logic                    result_valid,
    output logic                    result_is_store,
    output logic [rob_len-1:0]      result_rob_idx,
    output logic [prf_len-1:0]      result_dest_preg_idx,
    output logic [xlen-1:0]         result_value
);

    // station to memory unit
    logic               issue_valid;
    mem_func_t          issue_func;
    logic [xlen-1:0]    issue_base;
    logic [xlen-1:0]    issue_data;
    logic [xlen-1:0]    issue_offset;
    logic [prf_len-1:0] issue_dest_preg_idx;
    logic [rob_len-1:0] issue_rob_idx;

    rs_mem #(.rs_size(rs_size)) i_rs_mem (
        .clock              (clock),
        .rst_n              (rst_n),
        .enable             (enable),
        .mem_func           (mem_func),
        .opa_preg_idx       (opa_preg_idx),
        .opb_preg_idx       (opb_preg_idx),
        .opa_ready          (opa_ready),
        .opb_ready          (opb_ready),
        .opa_value          (opa_value),
        .opb_value          (opb_value),
        .offset             (offset),
        .dest_preg_idx      (dest_preg_idx),
        .rob_idx            (rob_idx),
        .cdb_valid          (cdb_valid),
        .cdb_tag            (cdb_tag),
        .cdb_value          (cdb_value),
        .commit_mis_pred    (commit_mis_pred),
        .full               (full),
        .issue_valid        (issue_valid),
        .issue_func         (issue_func),
        .issue_base         (issue_base),
        .issue_data         (issue_data),
        .issue_offset       (issue_offset),
        .issue_dest_preg_idx(issue_dest_preg_idx),
        .issue_rob_idx      (issue_rob_idx)
    );

    mem_unit i_mem_unit (
        .clock               (clock),
        .rst_n               (rst_n),
        .commit_mis_pred     (commit_mis_pred),
        .issue_valid         (issue_valid),
        .issue_func          (issue_func),
        .issue_base          (issue_base),
        .issue_data          (issue_data),
        .issue_offset        (issue_offset),
        .issue_dest_preg_idx (issue_dest_preg_idx),
        .issue_rob_idx       (issue_rob_idx),
        .result_valid        (result_valid),
        .result_is_store     (result_is_store),
        .result_rob_idx      (result_rob_idx),
        .result_dest_preg_idx(result_dest_preg_idx),
        .result_value        (result_value)
    );

endmodule

`default_nettype wire

//--- mem_issue_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module mem_issue_asserts import mem_issue_pkg::*; (
    input wire logic               clock,
    input wire logic               rst_n,
    input wire logic               enable,
    input wire logic               full,
    input wire logic               commit_mis_pred,
    input wire logic               issue_valid,
    input wire logic [rob_len-1:0] issue_rob_idx
);

    no_dispatch_when_full: assert property (@(posedge clock) disable iff (!rst_n)
        full |-> !enable) else $error("dispatch while the station is full");

    no_double_issue: assert property (@(posedge clock) disable iff (!rst_n)
        issue_valid ##1 issue_valid |-> issue_rob_idx != $past(issue_rob_idx))
        else $error("same rob index issued on two consecutive cycles");

    full_low_after_reset: assert property (@(posedge clock)
        !rst_n |=> !full) else $error("full high right after reset");

    no_issue_after_flush: assert property (@(posedge clock) disable iff (!rst_n)
        commit_mis_pred |=> !issue_valid) else $error("issue in the cycle after a flush");

endmodule

bind rs_mem mem_issue_asserts i_asserts (
    .clock          (clock),
    .rst_n          (rst_n),
    .enable         (enable),
    .full           (full),
    .commit_mis_pred(commit_mis_pred),
    .issue_valid    (issue_valid),
    .issue_rob_idx  (issue_rob_idx)
);

`default_nettype wire

//--- tb_mem_checker.sv
`timescale 1ns/10ps
`default_nettype none

module tb_mem_checker import mem_issue_pkg::*; (
    input  wire logic               clock,
    input  wire logic               rst_n,
    input  wire logic               enable,
    input  wire mem_func_t          mem_func,
    input  wire logic [prf_len-1:0] opa_preg_idx,
    input  wire logic [prf_len-1:0] opb_preg_idx,
    input  wire logic               opa_ready,
    input  wire logic               opb_ready,
    input  wire logic [xlen-1:0]    offset,
    input  wire logic [prf_len-1:0] dest_preg_idx,
    input  wire logic [rob_len-1:0] rob_idx,
    input  wire logic [xlen-1:0]    exp_base,   // resolved operands from the stimulus
    input  wire logic [xlen-1:0]    exp_data,
    input  wire logic               cdb_valid,
    input  wire logic [prf_len-1:0] cdb_tag,
    input  wire logic               commit_mis_pred,
    input  wire logic               result_valid,
    input  wire logic               result_is_store,
    input  wire logic [rob_len-1:0] result_rob_idx,
    input  wire logic [prf_len-1:0] result_dest_preg_idx,
    input  wire logic [xlen-1:0]    result_value,
    output int                      errors,
    output int                      checks,
    output int                      outstanding,
    output logic [2**rob_len-1:0]   busy
);

    localparam int word_w = $clog2(mem_words);
    localparam int n_rob  = 2**rob_len;

    mem_func_t          t_func[n_rob];
    logic [prf_len-1:0] t_dest[n_rob];
    logic [xlen-1:0]    t_base[n_rob];
    logic [xlen-1:0]    t_data[n_rob];
    logic [xlen-1:0]    t_off [n_rob];
    logic [prf_len-1:0] t_tag_a[n_rob];
    logic [prf_len-1:0] t_tag_b[n_rob];
    logic [n_rob-1:0]   pend_a;
    logic [n_rob-1:0]   pend_b;
    logic [xlen-1:0]    model[mem_words];    // memory as seen by completed stores

    assign outstanding = $countones(busy);

    task automatic compare(input string name, input logic [xlen-1:0] expv,
                           input logic [xlen-1:0] actv);
        checks++;
        if (actv !== expv) begin
            errors++;
            $display("FAILED %s rob %0d: expected %h, actual %h", name, result_rob_idx,
                     expv, actv);
        end
    endtask

    task automatic check_result();
        mem_func_t         f;
        logic [xlen-1:0]   addr;
        logic [xlen-1:0]   expv;
        logic [word_w-1:0] w;
        logic [1:0]        lane;
        logic [7:0]        b;
        if (!busy[result_rob_idx]) begin
            errors++;
            $display("completion for rob %0d which is not outstanding", result_rob_idx);
            return;
        end
        f    = t_func[result_rob_idx];
        addr = t_base[result_rob_idx] + t_off[result_rob_idx];
        w    = addr[word_w+1:2];
        lane = addr[1:0];
        b    = model[w][8*lane +: 8];
        if (pend_a[result_rob_idx] || pend_b[result_rob_idx]) begin
            errors++;
            $display("rob %0d completed before its tags were broadcast", result_rob_idx);
        end
        case (f)
            mem_lb:  expv = {{(xlen-8){b[7]}}, b};
            mem_lbu: expv = {{(xlen-8){1'b0}}, b};
            mem_sw:  expv = t_data[result_rob_idx];
            mem_sb:  expv = {(xlen/8){t_data[result_rob_idx][7:0]}};
            default: expv = model[w];
        endcase
        compare("dest", xlen'(t_dest[result_rob_idx]), xlen'(result_dest_preg_idx));
        compare("is_store", xlen'(is_store(f)), xlen'(result_is_store));
        compare("value", expv, result_value);
        if (f == mem_sw) model[w] = expv;
        if (f == mem_sb) model[w][8*lane +: 8] = expv[7:0];
        busy[result_rob_idx] = 1'b0;
    endtask

    always @(posedge clock) begin
        if (!rst_n) begin
            busy = '0;
            for (int m = 0; m < mem_words; m++) model[m] = '0;
        end else begin
            if (result_valid) check_result();   // a result visible at a flush still counts
            if (commit_mis_pred) begin
                busy = '0;
            end else begin
                for (int r = 0; r < n_rob; r++) begin
                    if (cdb_valid && busy[r] && t_tag_a[r] == cdb_tag) pend_a[r] = 1'b0;
                    if (cdb_valid && busy[r] && t_tag_b[r] == cdb_tag) pend_b[r] = 1'b0;
                end
                if (enable) begin
                    t_func[rob_idx]  = mem_func;
                    t_dest[rob_idx]  = dest_preg_idx;
                    t_base[rob_idx]  = exp_base;
                    t_data[rob_idx]  = exp_data;
                    t_off[rob_idx]   = offset;
                    t_tag_a[rob_idx] = opa_preg_idx;
                    t_tag_b[rob_idx] = opb_preg_idx;
                    pend_a[rob_idx]  = !opa_ready && !(cdb_valid && cdb_tag == opa_preg_idx);
                    pend_b[rob_idx]  = !opb_ready && !(cdb_valid && cdb_tag == opb_preg_idx);
                    busy[rob_idx]    = 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- tb_mem_issue.sv
`timescale 1ns/10ps
`default_nettype none

module tb_mem_issue import mem_issue_pkg::*; ();

    localparam int rs_size    = 8;
    localparam int n_instr    = 300;
    localparam int max_out    = 16;
    localparam int wait_limit = 2000;

    logic clock, rst_n, enable, opa_ready, opb_ready, cdb_valid, commit_mis_pred;
    mem_func_t          mem_func;
    logic [prf_len-1:0] opa_preg_idx, opb_preg_idx, dest_preg_idx, cdb_tag;
    logic [xlen-1:0]    opa_value, opb_value, offset, cdb_value, exp_base, exp_data;
    logic [rob_len-1:0] rob_idx;
    logic               full, result_valid, result_is_store;
    logic [rob_len-1:0] result_rob_idx;
    logic [prf_len-1:0] result_dest_preg_idx;
    logic [xlen-1:0]    result_value;
    int                 errors, checks, outstanding;
    logic [2**rob_len-1:0] busy;

    logic [31:0]        lfsr = 32'd31995;
    logic [prf_len-1:0] next_tag;
    logic [rob_len-1:0] next_rob;
    logic [prf_len-1:0] q_tag[$];    // pending broadcasts
    logic [xlen-1:0]    q_val[$];
    int                 q_due[$];
    logic [prf_len-1:0] held_tag[rs_size];
    logic [xlen-1:0]    held_val[rs_size];
    int                 held_n, cyc, fails, lat, n, sent;
    logic               was_flush;

    mem_issue_top #(.rs_size(rs_size)) i_mem_issue_top (.*);

    tb_mem_checker i_checker (.*);

    always #2 clock = ~clock;
    always @(posedge clock) cyc <= cyc + 1;

    ////////////////////////////////////////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] rand_bits(input int nb);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < nb; k++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    task automatic idle();
        enable          = 1'b0;
        cdb_valid       = 1'b0;
        commit_mis_pred = 1'b0;
    endtask

    task automatic schedule(input logic [prf_len-1:0] tag, input logic [xlen-1:0] val,
                            input int delay);
        if (delay < 0) begin    // withheld until released by hand
            held_tag[held_n] = tag;
            held_val[held_n] = val;
            held_n++;
        end else begin
            q_tag.push_back(tag);
            q_val.push_back(val);
            q_due.push_back(cyc + delay);
        end
    endtask

    task automatic put_instr(input mem_func_t f, input logic [xlen-1:0] base,
                             input logic [xlen-1:0] data, input logic [xlen-1:0] off,
                             input logic wait_a, input logic wait_b, input int delay);
        enable        = 1'b1;
        mem_func      = f;
        offset        = off;
        dest_preg_idx = prf_len'(rand_bits(prf_len));
        rob_idx       = next_rob;
        next_rob      = next_rob + rob_len'(1);
        exp_base      = base;
        exp_data      = data;
        opa_ready     = !wait_a;
        opb_ready     = !wait_b;
        opa_value     = wait_a ? rand_bits(xlen) : base;   // junk while waiting
        opb_value     = wait_b ? rand_bits(xlen) : data;
        opa_preg_idx  = '0;
        opb_preg_idx  = '0;
        if (wait_a) begin
            opa_preg_idx = next_tag;
            schedule(next_tag, base, delay);
            next_tag++;
        end
        if (wait_b) begin
            opb_preg_idx = next_tag;
            schedule(next_tag, data, delay);
            next_tag++;
        end
    endtask

    // one broadcast per cycle with the oldest due entry first
    task automatic cdb_step();
        for (int k = 0; k < q_due.size(); k++) begin
            if (q_due[k] <= cyc) begin
                cdb_valid = 1'b1;
                cdb_tag   = q_tag[k];
                cdb_value = q_val[k];
                q_tag.delete(k);
                q_val.delete(k);
                q_due.delete(k);
                break;
            end
        end
    endtask

    task automatic drain();
        n = 0;
        while ((outstanding != 0 || q_due.size() != 0) && n < wait_limit) begin
            @(negedge clock);
            idle();
            cdb_step();
            n++;
        end
        if (n >= wait_limit) begin
            fails++;
            $display("timeout: %0d instructions never completed", outstanding);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        clock     = 1'b0;
        rst_n     = 1'b0;
        cyc       = 0;
        fails     = 0;
        held_n    = 0;
        was_flush = 1'b0;
        idle();
        mem_func      = mem_lw;
        opa_preg_idx  = '0;
        opb_preg_idx  = '0;
        dest_preg_idx = '0;
        opa_ready     = 1'b1;
        opb_ready     = 1'b1;
        opa_value     = '0;
        opb_value     = '0;
        offset        = '0;
        rob_idx       = '0;
        cdb_tag       = '0;
        cdb_value     = '0;
        exp_base      = '0;
        exp_data      = '0;
        next_tag      = '0;
        next_rob      = '0;
        repeat (2) @(posedge clock);
        @(negedge clock);
        rst_n = 1'b1;

        // lone ready load has a fixed latency
        @(negedge clock);
        put_instr(mem_lw, 8, 0, 4, 1'b0, 1'b0, 0);
        lat = 0;
        do begin
            @(negedge clock);
            idle();
            lat++;
        end while (!result_valid && lat < 20);
        if (lat != 3) begin
            fails++;
            $display("FAILED latency: expected 3, actual %0d", lat);
        end

        // fill the station with withheld tags
        for (int k = 0; k < rs_size; k++) begin
            @(negedge clock);
            idle();
            put_instr(mem_sw, rand_bits(6), rand_bits(xlen), rand_bits(5), 1'b1, 1'b0, -1);
        end
        @(negedge clock);
        idle();
        if (!full) begin
            fails++;
            $display("FAILED full: expected 1, actual 0");
        end
        cdb_valid = 1'b1;
        cdb_tag   = held_tag[0];
        cdb_value = held_val[0];
        n = 0;
        do begin
            @(negedge clock);
            idle();
            n++;
        end while (full && n < wait_limit);
        if (full) begin
            fails++;
            $display("full stayed high after a tag was broadcast");
        end
        for (int k = 1; k < held_n; k++) schedule(held_tag[k], held_val[k], 0);
        drain();

        // tag broadcast in its own dispatch cycle
        @(negedge clock);
        idle();
        put_instr(mem_lbu, 20, 0, 1, 1'b1, 1'b0, 0);
        cdb_step();
        drain();

        // random traffic with flushes
        sent = 0;
        n    = 0;
        while (sent < n_instr && n < 50 * n_instr) begin
            @(negedge clock);
            was_flush = commit_mis_pred;
            idle();
            n++;
            if (was_flush && full) begin
                fails++;
                $display("full still high after a flush");
            end
            if (rand_bits(6) == 0) begin
                commit_mis_pred = 1'b1;
                q_tag.delete();
                q_val.delete();
                q_due.delete();
            end else begin
                if (!full && outstanding < max_out && !busy[next_rob] && rand_bits(1) != 0) begin
                    put_instr(mem_func_t'(3'(rand_bits(3) % 5)), rand_bits(7),
                              rand_bits(xlen), rand_bits(6), rand_bits(2) == 0,
                              rand_bits(2) == 0, int'(rand_bits(3)));
                    sent++;
                end
                cdb_step();
            end
        end
        if (sent < n_instr) begin
            fails++;
            $display("timeout: only %0d instructions dispatched", sent);
        end
        drain();

        $display("checks: %0d, value errors: %0d, other errors: %0d", checks, errors, fails);
        if (errors == 0 && fails == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- mem_issue.f
mem_issue_pkg.sv
psel_gen.sv
rs_mem.sv
mem_unit.sv
mem_issue_top.sv
mem_issue_asserts.sv
tb_mem_checker.sv
tb_mem_issue.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_mem_issue
FLIST     = mem_issue.f
LOG       = sim.log

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
